/* build.f */
+incdir+include
hw/glue_pkg.sv
hw/rtc_clock.sv
hw/sys_control.sv
hw/cpu_bus_merge.sv
hw/minimig_glue.sv
bench/tb_clock_gen.sv
bench/minimig_glue_assert.sv
bench/minimig_glue_tb.sv

/* Bender.yml */
package:
  name: minimig_glue

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/glue_pkg.sv
      - hw/rtc_clock.sv
      - hw/sys_control.sv
      - hw/cpu_bus_merge.sv
      - hw/minimig_glue.sv
  - target: simulation
    files:
      - bench/tb_clock_gen.sv
      - bench/minimig_glue_assert.sv
      - bench/minimig_glue_tb.sv

/* bench/minimig_glue_tb.sv */
// testbench for the minimig glue top with directed tests and a cycle model compare
`timescale 1ns/1ns

module minimig_glue_tb;

	localparam int   TICK_DIV = 10;    // short seconds for simulation
	localparam logic NTSC_VAL = 1'b1;
	// cycles for reset and tests 1 to 6
	localparam int RUN_CYCLES = 10 + 2 + 33 + 610 + 8 + 32 + 16;
	localparam int MAX_CYCLES = 2 * RUN_CYCLES;

	logic                  clk;
	logic                  rst_n;
	logic                  rtc_flag;
	glue_pkg::rtc_time_t   rtc_time;
	glue_pkg::nibble_sel_t cpu_addr;
	logic                  cpu_rd;
	logic                  cpu_hwr;
	logic                  cpu_lwr;
	logic                  cpu_reset_in;
	logic                  cpu_rst_req;
	logic                  clk7_en;
	logic                  ntsc_cfg;
	logic                  sel_rtc;
	logic                  sel_cia_a;
	glue_pkg::data_word_t  mem_rdata;
	glue_pkg::data_word_t  cia_rdata;
	glue_pkg::data_word_t  cart_rdata;
	glue_pkg::data_word_t  agnus_rdata;
	glue_pkg::data_word_t  paula_rdata;
	glue_pkg::data_word_t  denise_rdata;
	glue_pkg::data_word_t  user_rdata;
	logic                  int7;
	glue_pkg::ipl_t        paula_ipl;
	glue_pkg::data_word_t  cpu_rdata;
	glue_pkg::data_word_t  custom_rdata;
	glue_pkg::ipl_t        cpu_ipl;
	logic                  cpu_reset_n;
	logic                  ovl;
	logic                  ntsc;
	logic                  rst_out;

	// model state
	glue_pkg::rtc_time_t m_time;
	logic                m_flag_q;
	int                  m_cnt;   // seconds prescaler
	logic [1:0]          m_sync;  // cpu reset pipe
	logic                m_ovl;
	logic                m_ntsc;

	int                  checks = 0;
	int                  errors = 0;
	int                  cycles = 0;
	int                  seed;
	glue_pkg::rtc_time_t loaded;  // last time the host wrote

	tb_clock_gen #(.PERIOD(8), .RESET_CYCLES(8)) u_clock_gen (.clk(clk), .rst_n(rst_n));

	minimig_glue #(.TICK_DIV(TICK_DIV), .NTSC(NTSC_VAL)) u_minimig_glue (.*);

	// ----------------------------------------
	// reference model
	// ----------------------------------------
	// one bcd step of the seconds byte that holds at 59
	function automatic logic [7:0] bcd_next(input logic [7:0] s);
		if (s[3:0] < 4'd9)
			return {s[7:4], s[3:0] + 4'd1};
		else if (s[7:4] < 4'd5)
			return {s[7:4] + 4'd1, 4'd0};
		return s;
	endfunction

	// expected output picked by index
	function automatic logic [15:0] ref_model(input int sel);
		logic [15:0] rtc_word;
		rtc_word = (sel_rtc && cpu_rd) ? 16'(m_time[cpu_addr * 4 +: 4]) : 16'h0;
		case (sel)
			0: return mem_rdata | cia_rdata | cart_rdata | rtc_word;
			1: return agnus_rdata | paula_rdata | denise_rdata | user_rdata;
			2: return int7 ? 16'h0 : 16'(paula_ipl);  // level 7 wins
			3: return 16'(m_sync[1]);
			4: return 16'(m_ovl);
			5: return 16'(m_ntsc);
			default: return cpu_reset_in ? 16'h0 : 16'h1;  // rst_out
		endcase
	endfunction

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			m_time   <= '0;
			m_flag_q <= 1'b0;
			m_cnt    <= 0;
			m_sync   <= 2'b00;
			m_ovl    <= 1'b1;
			m_ntsc   <= NTSC_VAL;
		end else begin
			m_flag_q <= rtc_flag;
			m_sync   <= {m_sync[0], cpu_reset_in & ~cpu_rst_req};
			if (m_flag_q != rtc_flag) begin
				m_time <= {rtc_time[63:8], 8'h00};  // seconds restart
				m_cnt  <= 0;
			end else if (m_cnt == TICK_DIV - 1) begin
				m_time[7:0] <= bcd_next(m_time[7:0]);
				m_cnt       <= 0;
			end else begin
				m_cnt <= m_cnt + 1;
			end
			if (!m_sync[1] || !cpu_reset_in)
				m_ovl <= 1'b1;
			else if (sel_cia_a && (cpu_hwr || cpu_lwr))
				m_ovl <= 1'b0;
			if (clk7_en && !cpu_reset_in)
				m_ntsc <= ntsc_cfg;
		end
	end

	// ----------------------------------------
	// checking
	// ----------------------------------------
	task automatic check_value(input string name, input logic [15:0] actual,
		input logic [15:0] expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("MISMATCH %s at %0t: got 0x%h, expected 0x%h",
				name, $time, actual, expected);
		end
	endtask

	// compare every cycle well after the rising edge
	always @(posedge clk) begin
		#2;
		if (rst_n) begin
			check_value("cpu_rdata", cpu_rdata, ref_model(0));
			check_value("custom_rdata", custom_rdata, ref_model(1));
			check_value("cpu_ipl", cpu_ipl, ref_model(2));
			check_value("cpu_reset_n", cpu_reset_n, ref_model(3));
			check_value("ovl", ovl, ref_model(4));
			check_value("ntsc", ntsc, ref_model(5));
			check_value("rst_out", rst_out, ref_model(6));
		end
	end

	task automatic wait_negedges(input int n);
		repeat (n) @(negedge clk);
	endtask

	task automatic end_test(input string name, input int errs_at_start);
		if (errors == errs_at_start)
			$display("[%s] ok", name);
		else
			$display("[%s] %0d errors", name, errors - errs_at_start);
	endtask

	// ----------------------------------------
	// stimulus
	// ----------------------------------------
	initial begin : stimulus
		int          base;
		int          s;
		logic [7:0]  exp_sec;
		logic [15:0] rtc_word;
		logic        held;
		int          assert_fails;
		seed = $urandom(86);
		{rtc_flag, rtc_time, cpu_addr, cpu_rd, cpu_hwr, cpu_lwr} = '0;
		{cpu_reset_in, cpu_rst_req, clk7_en, ntsc_cfg, sel_rtc, sel_cia_a} = '0;
		{mem_rdata, cia_rdata, cart_rdata, agnus_rdata} = '0;
		{paula_rdata, denise_rdata, user_rdata, int7, paula_ipl} = '0;
		@(posedge rst_n);
		@(negedge clk);

		// test 1 covers reset values and the cpu reset release
		base = errors;
		check_value("cpu_reset_n", cpu_reset_n, 16'h0);
		check_value("ovl", ovl, 16'h1);
		check_value("ntsc", ntsc, 16'(NTSC_VAL));
		cpu_reset_in = 1'b1;
		wait_negedges(1);
		check_value("cpu_reset_n", cpu_reset_n, 16'h0);  // one stage only
		wait_negedges(1);
		check_value("cpu_reset_n", cpu_reset_n, 16'h1);
		end_test("reset_release", base);

		// test 2 loads a host time and reads every nibble
		base = errors;
		loaded   = {$urandom, $urandom};
		rtc_time = loaded;
		rtc_flag = ~rtc_flag;
		sel_rtc  = 1'b1;
		cpu_rd   = 1'b1;
		wait_negedges(1);
		for (int n = 0; n < 16; n++) begin
			cpu_addr = 4'(n);
			wait_negedges(1);
			check_value("cpu_rdata", cpu_rdata, (n < 2) ? 16'h0 : 16'(loaded[n * 4 +: 4]));
		end
		cpu_rd = 1'b0;
		for (int n = 0; n < 16; n++) begin
			cpu_addr = 4'(n);
			wait_negedges(1);
			check_value("cpu_rdata", cpu_rdata, 16'h0);  // rtc stays off the bus without a read
		end
		end_test("rtc_readout", base);

		// test 3 counts seconds at one tick per 10 cycles
		base = errors;
		rtc_time = {loaded[63:8], 8'h55};  // low byte dropped by the load
		rtc_flag = ~rtc_flag;
		cpu_rd   = 1'b1;
		cpu_addr = 4'd0;
		for (int k = 0; k <= 60; k++) begin
			s       = (k > 59) ? 59 : k;
			exp_sec = {4'(s / 10), 4'(s % 10)};
			wait_negedges(4);  // mid tick
			check_value("rtc seconds ones", cpu_rdata, 16'(exp_sec[3:0]));
			cpu_addr = 4'd1;
			wait_negedges(1);
			check_value("rtc seconds tens", cpu_rdata, 16'(exp_sec[7:4]));
			cpu_addr = 4'd0;
			wait_negedges(5);
		end
		loaded = {loaded[63:8], 8'h59};
		end_test("rtc_seconds", base);

		// test 4 walks the overlay latch
		base    = errors;
		sel_rtc = 1'b0;
		cpu_rd  = 1'b0;
		check_value("ovl", ovl, 16'h1);
		cpu_lwr = 1'b1;
		wait_negedges(1);
		check_value("ovl", ovl, 16'h1);  // other address leaves the latch alone
		cpu_lwr   = 1'b0;
		sel_cia_a = 1'b1;
		cpu_hwr   = 1'b1;
		wait_negedges(1);
		check_value("ovl", ovl, 16'h0);  // first cia a write
		sel_cia_a    = 1'b0;
		cpu_hwr      = 1'b0;
		cpu_reset_in = 1'b0;
		wait_negedges(1);
		check_value("ovl", ovl, 16'h1);
		cpu_reset_in = 1'b1;
		wait_negedges(4);
		check_value("cpu_reset_n", cpu_reset_n, 16'h1);
		end_test("overlay", base);

		// test 5 drives random read words and interrupt levels
		base = errors;
		for (int i = 0; i < 32; i++) begin
			mem_rdata    = 16'($urandom);
			cia_rdata    = 16'($urandom);
			cart_rdata   = 16'($urandom);
			agnus_rdata  = 16'($urandom);
			paula_rdata  = 16'($urandom);
			denise_rdata = 16'($urandom);
			user_rdata   = 16'($urandom);
			int7         = 1'($urandom);
			paula_ipl    = 3'($urandom);
			sel_rtc      = 1'($urandom);
			cpu_rd       = 1'($urandom);
			cpu_addr     = 4'($urandom);
			wait_negedges(1);
			rtc_word = (sel_rtc && cpu_rd) ? 16'(loaded[cpu_addr * 4 +: 4]) : 16'h0;
			check_value("cpu_rdata", cpu_rdata, mem_rdata | cia_rdata | cart_rdata | rtc_word);
			check_value("custom_rdata", custom_rdata,
				agnus_rdata | paula_rdata | denise_rdata | user_rdata);
			check_value("cpu_ipl", cpu_ipl, int7 ? 16'h0 : 16'(paula_ipl));
		end
		{mem_rdata, cia_rdata, cart_rdata, agnus_rdata} = '0;
		{paula_rdata, denise_rdata, user_rdata, int7, paula_ipl} = '0;
		{sel_rtc, cpu_rd} = 2'b00;
		end_test("bus_merge", base);

		// test 6 checks the video standard follows only during reset
		base         = errors;
		clk7_en      = 1'b1;
		cpu_reset_in = 1'b0;
		for (int i = 0; i < 8; i++) begin
			ntsc_cfg = 1'($urandom);
			wait_negedges(1);
			check_value("ntsc", ntsc, 16'(ntsc_cfg));
		end
		held         = ntsc_cfg;
		cpu_reset_in = 1'b1;
		for (int i = 0; i < 8; i++) begin
			ntsc_cfg = ~ntsc_cfg;
			wait_negedges(1);
			check_value("ntsc", ntsc, 16'(held));
		end
		end_test("ntsc_latch", base);

		assert_fails = u_minimig_glue.u_sys_control.u_sys_assert.fail_count;
		$display("checks %0d, errors %0d, assertion failures %0d",
			checks, errors, assert_fails);
		if (errors == 0 && assert_fails == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

	// ----------------------------------------
	// watchdog
	// ----------------------------------------
	initial begin : watchdog
		while (cycles < MAX_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: tests did not finish within %0d cycles", MAX_CYCLES);
		$display("test failed");
		$finish;
	end

endmodule

/* bench/minimig_glue_assert.sv */
// concurrent checks on the cpu reset output, overlay latch and video standard
`timescale 1ns/1ns

module minimig_glue_assert (
	input logic clk,
	input logic rst_n,
	input logic sys_rst,
	input logic cpu_reset_n,
	input logic ovl,
	input logic ntsc
);

	int fail_count = 0;  // picked up by the testbench at the end

	// ----------------------------------------
	// cpu reset output
	// ----------------------------------------
	// two flop pipe, so low at the latest two samples later
	reset_follows_sys: assert property (@(posedge clk) disable iff (!rst_n)
		sys_rst |-> ##[0:2] !cpu_reset_n)
	else begin
		fail_count++;
		$error("cpu_reset_n not low within two cycles of sys_rst");
	end

	// ----------------------------------------
	// overlay
	// ----------------------------------------
	ovl_set_in_reset: assert property (@(posedge clk) disable iff (!rst_n)
		!cpu_reset_n |=> ovl)
	else begin
		fail_count++;
		$error("ovl not set one cycle after cpu_reset_n low");
	end

	// ----------------------------------------
	// video standard
	// ----------------------------------------
	// latch only opens while the system is in reset
	ntsc_frozen: assert property (@(posedge clk) disable iff (!rst_n)
		!sys_rst |=> $stable(ntsc))
	else begin
		fail_count++;
		$error("ntsc moved while sys_rst was low");
	end

endmodule

bind sys_control minimig_glue_assert u_sys_assert (
	.clk         (clk),
	.rst_n       (rst_n),
	.sys_rst     (sys_rst),
	.cpu_reset_n (cpu_reset_n),
	.ovl         (ovl),
	.ntsc        (ntsc)
);

/* bench/tb_clock_gen.sv */
// testbench clock and power-on reset source
`timescale 1ns/1ns

module tb_clock_gen #(
	parameter int PERIOD       = 8,  // ns
	parameter int RESET_CYCLES = 8
) (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// release on a falling edge, away from the dut sampling edge
	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
	end

endmodule

/* hw/minimig_glue.sv */
// minimig glue top: rtc, system control and cpu read bus merge
`timescale 1ns/1ns
`include "glue_consts.svh"

module minimig_glue #(
	parameter int   TICK_DIV = `GLUE_TICK_DIV,  // rtc clocks per second
	parameter logic NTSC     = 1'b0             // power-up video standard
) (
	input  logic                  clk,
	input  logic                  rst_n,

	// host rtc interface
	input  logic                  rtc_flag,      // toggles on a new time
	input  glue_pkg::rtc_time_t   rtc_time,

	// cpu side
	input  glue_pkg::nibble_sel_t cpu_addr,      // address bits 5..2
	input  logic                  cpu_rd,
	input  logic                  cpu_hwr,
	input  logic                  cpu_lwr,
	input  logic                  cpu_reset_in,  // active low
	input  logic                  cpu_rst_req,
	input  logic                  clk7_en,
	input  logic                  ntsc_cfg,

	// address decode
	input  logic                  sel_rtc,
	input  logic                  sel_cia_a,

	// read data from the chips outside
	input  glue_pkg::data_word_t  mem_rdata,
	input  glue_pkg::data_word_t  cia_rdata,
	input  glue_pkg::data_word_t  cart_rdata,
	input  glue_pkg::data_word_t  agnus_rdata,
	input  glue_pkg::data_word_t  paula_rdata,
	input  glue_pkg::data_word_t  denise_rdata,
	input  glue_pkg::data_word_t  user_rdata,

	// interrupts
	input  logic                  int7,
	input  glue_pkg::ipl_t        paula_ipl,

	// outputs
	output glue_pkg::data_word_t  cpu_rdata,
	output glue_pkg::data_word_t  custom_rdata,
	output glue_pkg::ipl_t        cpu_ipl,
	output logic                  cpu_reset_n,
	output logic                  ovl,
	output logic                  ntsc,
	output logic                  rst_out        // system reset status
);

	glue_pkg::bcd_digit_t rtc_nibble;  // rtc readout to the merge
	logic                 sys_rst;

	// ----------------------------------------
	// rtc
	// ----------------------------------------
	rtc_clock #(
		.TICK_DIV (TICK_DIV)
	) u_rtc_clock (
		.clk        (clk),
		.rst_n      (rst_n),
		.rtc_flag   (rtc_flag),
		.rtc_time   (rtc_time),
		.nibble_sel (cpu_addr),
		.rtc_nibble (rtc_nibble)
	);

	// ----------------------------------------
	// reset, overlay, video standard
	// ----------------------------------------
	sys_control #(
		.NTSC (NTSC)
	) u_sys_control (
		.clk          (clk),
		.rst_n        (rst_n),
		.clk7_en      (clk7_en),
		.cpu_reset_in (cpu_reset_in),
		.cpu_rst_req  (cpu_rst_req),
		.sel_cia_a    (sel_cia_a),
		.cpu_hwr      (cpu_hwr),
		.cpu_lwr      (cpu_lwr),
		.ntsc_cfg     (ntsc_cfg),
		.sys_rst      (sys_rst),
		.cpu_reset_n  (cpu_reset_n),
		.ovl          (ovl),
		.ntsc         (ntsc)
	);

	assign rst_out = sys_rst;

	// ----------------------------------------
	// read buses and ipl
	// ----------------------------------------
	cpu_bus_merge u_cpu_bus_merge (
		.cpu_rd       (cpu_rd),
		.sel_rtc      (sel_rtc),
		.rtc_nibble   (rtc_nibble),
		.mem_rdata    (mem_rdata),
		.cia_rdata    (cia_rdata),
		.cart_rdata   (cart_rdata),
		.agnus_rdata  (agnus_rdata),
		.paula_rdata  (paula_rdata),
		.denise_rdata (denise_rdata),
		.user_rdata   (user_rdata),
		.int7         (int7),
		.paula_ipl    (paula_ipl),
		.cpu_rdata    (cpu_rdata),
		.custom_rdata (custom_rdata),
		.cpu_ipl      (cpu_ipl)
	);

endmodule

/* hw/cpu_bus_merge.sv */
// read data merge for cpu and custom buses, level 7 interrupt override
`timescale 1ns/1ns

module cpu_bus_merge (
	input  logic                 cpu_rd,        // cpu read cycle
	input  logic                 sel_rtc,       // rtc address decode
	input  glue_pkg::bcd_digit_t rtc_nibble,    // selected rtc nibble
	input  glue_pkg::data_word_t mem_rdata,     // memory bus read data
	input  glue_pkg::data_word_t cia_rdata,     // both cias, one byte each
	input  glue_pkg::data_word_t cart_rdata,    // action replay cartridge
	input  glue_pkg::data_word_t agnus_rdata,
	input  glue_pkg::data_word_t paula_rdata,
	input  glue_pkg::data_word_t denise_rdata,
	input  glue_pkg::data_word_t user_rdata,
	input  logic                 int7,          // freeze request from the cartridge
	input  glue_pkg::ipl_t       paula_ipl,     // interrupt level from paula
	output glue_pkg::data_word_t cpu_rdata,
	output glue_pkg::data_word_t custom_rdata,
	output glue_pkg::ipl_t       cpu_ipl
);

	glue_pkg::data_word_t rtc_rdata;  // rtc word, zero unless read

	// ----------------------------------------
	// cpu bus
	// ----------------------------------------
	// rtc has no decode of its own, so gate it here
	assign rtc_rdata = (sel_rtc && cpu_rd) ? glue_pkg::data_word_t'(rtc_nibble) : '0;

	// every source drives zero when not addressed
	assign cpu_rdata = mem_rdata
		| cia_rdata
		| cart_rdata
		| rtc_rdata;

	// ----------------------------------------
	// custom bus
	// ----------------------------------------
	assign custom_rdata = agnus_rdata
		| paula_rdata
		| denise_rdata
		| user_rdata;

	// ----------------------------------------
	// interrupts
	// ----------------------------------------
	// level 7 is all zeros on the active-low lines, nmi for the freeze
	assign cpu_ipl = int7 ? 3'b000 : paula_ipl;

endmodule

/* hw/sys_control.sv */
// system reset, cpu reset synchronizer, kickstart overlay and pal/ntsc latch
`timescale 1ns/1ns
`include "glue_consts.svh"

module sys_control #(
	parameter logic NTSC = 1'b0  // video standard after power-up
) (
	input  logic clk,
	input  logic rst_n,
	input  logic clk7_en,       // 7 MHz enable
	input  logic cpu_reset_in,  // cpu reset in, active low
	input  logic cpu_rst_req,   // reset request from the host
	input  logic sel_cia_a,     // cia a address decode
	input  logic cpu_hwr,       // upper byte write strobe
	input  logic cpu_lwr,       // lower byte write strobe
	input  logic ntsc_cfg,      // requested video standard
	output logic sys_rst,       // system reset, active high
	output logic cpu_reset_n,   // cpu reset out, active low
	output logic ovl,           // kickstart overlay enable
	output logic ntsc           // active video standard
);

	localparam int STAGES = `GLUE_RST_STAGES;

	logic [STAGES-1:0] rst_sync;  // cpu reset pipe, shifts toward msb
	logic              rst_hold;  // any source holds the cpu in reset
	logic              cia_a_wr;

	// ----------------------------------------
	// reset derivation
	// ----------------------------------------
	assign sys_rst  = ~cpu_reset_in;
	assign rst_hold = cpu_rst_req | sys_rst;

	// release and assert both take STAGES clocks
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			rst_sync <= '0;
		else
			rst_sync <= {rst_sync[STAGES-2:0], ~rst_hold};
	end

	assign cpu_reset_n = rst_sync[STAGES-1];

	// ----------------------------------------
	// kickstart overlay
	// ----------------------------------------
	// rom mirrored at 0 until the boot code first touches cia a
	assign cia_a_wr = sel_cia_a & (cpu_hwr | cpu_lwr);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			ovl <= 1'b1;
		else if (!cpu_reset_n || !cpu_reset_in)
			ovl <= 1'b1;  // any reset brings the overlay back, wins over a write
		else if (cia_a_wr)
			ovl <= 1'b0;
	end

	// ----------------------------------------
	// pal / ntsc
	// ----------------------------------------
	// a new standard only takes effect through a reset
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			ntsc <= NTSC;
		else if (clk7_en && sys_rst)
			ntsc <= ntsc_cfg;
	end

endmodule

/* hw/rtc_clock.sv */
// real-time clock register, host loaded, counts bcd seconds, nibble readout
`timescale 1ns/1ns
`include "glue_consts.svh"

module rtc_clock #(
	parameter int TICK_DIV = `GLUE_TICK_DIV  // clocks per second
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   rtc_flag,    // host toggles on a new time
	input  glue_pkg::rtc_time_t    rtc_time,    // time word from the host
	input  glue_pkg::nibble_sel_t  nibble_sel,  // cpu address 5..2
	output glue_pkg::bcd_digit_t   rtc_nibble
);

	// prescaler width, at least one bit for tiny dividers
	localparam int CNT_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(TICK_DIV - 1);

	logic                 flag_q;    // host flag, one cycle old
	logic                 load;      // host wrote a new time
	logic [CNT_W-1:0]     tick_cnt;  // seconds prescaler
	logic                 tick;      // last clock of the second
	glue_pkg::rtc_time_t  time_q;    // running time
	glue_pkg::bcd_digit_t sec_ones;
	glue_pkg::bcd_digit_t sec_tens;

	// ----------------------------------------
	// host load and prescaler
	// ----------------------------------------
	assign load = flag_q ^ rtc_flag;  // any edge of the toggle flag
	assign tick = (tick_cnt == CNT_LAST);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			flag_q   <= 1'b0;
			tick_cnt <= '0;
		end else begin
			flag_q <= rtc_flag;
			if (load || tick)
				tick_cnt <= '0;  // restart the second on a load
			else
				tick_cnt <= tick_cnt + 1'b1;
		end
	end

	// ----------------------------------------
	// time register
	// ----------------------------------------
	assign sec_ones = time_q[3:0];
	assign sec_tens = time_q[7:4];

	// seconds run 00..59 and then stay, minutes and up belong to the host
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			time_q <= '0;
		end else if (load) begin
			time_q <= {rtc_time[`GLUE_RTC_W-1:8], 8'h00};  // seconds restart at 00
		end else if (tick) begin
			if (sec_ones < 4'd9) begin
				time_q[3:0] <= sec_ones + 1'b1;
			end else if (sec_tens < 4'(`GLUE_SEC_MAX_TENS)) begin
				time_q[7:4] <= sec_tens + 1'b1;  // carry into tens
				time_q[3:0] <= 4'd0;
			end
			// at 59 nothing moves
		end
	end

	// ----------------------------------------
	// readout
	// ----------------------------------------
	// nibble n sits at bits 4n+3..4n
	assign rtc_nibble = time_q[{nibble_sel, 2'b00} +: 4];

endmodule

/* hw/glue_pkg.sv */
// shared bus, time and interrupt types for the minimig glue logic
`include "glue_consts.svh"

package glue_pkg;

	// ----------------------------------------
	// bus types
	// ----------------------------------------
	// one cpu or custom bus word
	typedef logic [`GLUE_DATA_W-1:0] data_word_t;

	// m68k interrupt level, active low
	typedef logic [2:0] ipl_t;

	// ----------------------------------------
	// rtc types
	// ----------------------------------------
	// packed host time, seconds in bits 7..0
	typedef logic [`GLUE_RTC_W-1:0] rtc_time_t;

	typedef logic [3:0] bcd_digit_t;  // one bcd digit / readout nibble

	// picks one of the sixteen nibbles, from cpu address 5..2
	typedef logic [3:0] nibble_sel_t;

endpackage

/* include/glue_consts.svh */
// glue logic constants: bus widths, rtc tick divider, reset depth
`ifndef GLUE_CONSTS_SVH
`define GLUE_CONSTS_SVH

// ----------------------------------------
// widths
// ----------------------------------------
`define GLUE_DATA_W 16       // cpu / custom data bus
`define GLUE_RTC_W 64        // sixteen bcd nibbles from the host

// ----------------------------------------
// timing
// ----------------------------------------
// clocks per second at 28.375 MHz
`define GLUE_TICK_DIV 28375160
`define GLUE_RST_STAGES 2    // flops on the cpu reset output

// largest tens digit of seconds, keeps the count at 59
`define GLUE_SEC_MAX_TENS 5

`endif
